// ==== common/bridge_settings.svh ====
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// Byte address width on both AXI and reqrsp.
`define BRIDGE_ADDR_W 16

// Data word width. Strobes follow as one bit per byte.
`define BRIDGE_DATA_W 32

// AXI transaction ID width.
`define BRIDGE_ID_W 4

// AXI burst length field width.
`define BRIDGE_LEN_W 8

// Maximum number of beats in flight downstream.
`define BRIDGE_META_DEPTH 4

`endif

// ==== common/bridge_pkg.sv ====
`include "bridge_settings.svh"

package bridge_pkg;

  // Vector types with a meaning on the bus.
  typedef logic [`BRIDGE_ADDR_W-1:0]   addr_t;
  typedef logic [`BRIDGE_DATA_W-1:0]   data_t;
  typedef logic [`BRIDGE_DATA_W/8-1:0] strb_t;
  typedef logic [`BRIDGE_ID_W-1:0]     id_t;
  typedef logic [`BRIDGE_LEN_W-1:0]    len_t;
  typedef logic [2:0]                  size_t;
  typedef logic [1:0]                  resp_t;

  // AXI response codes.
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Burst generator state.
  typedef enum logic {
    BURST_IDLE,
    BURST_BEATS
  } burst_state_e;

  // Arbiter state, held while a request waits for q_ready.
  typedef enum logic {
    ARB_FREE,
    ARB_HELD
  } arb_state_e;

endpackage

// ==== logic/burst_gen.sv ====
module burst_gen (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ax_valid_i,
  output logic               ax_ready_o,
  input  bridge_pkg::addr_t  ax_addr_i,
  input  bridge_pkg::id_t    ax_id_i,
  input  bridge_pkg::len_t   ax_len_i,
  input  bridge_pkg::size_t  ax_size_i,
  output logic               beat_valid_o,
  input  logic               beat_ready_i,
  output bridge_pkg::addr_t  beat_addr_o,
  output bridge_pkg::id_t    beat_id_o,
  output bridge_pkg::size_t  beat_size_o,
  output logic               beat_last_o,
  output logic               burst_active_o
);
  import bridge_pkg::*;

  burst_state_e state_q;
  len_t         cnt_q;
  addr_t        addr_q;
  id_t          id_q;
  size_t        size_q;
  addr_t        next_addr;
  logic         beat_fire;

  // First beat comes straight from the address channel.
  always_comb begin
    if (state_q == BURST_IDLE) begin
      beat_valid_o = ax_valid_i;
      beat_addr_o  = ax_addr_i;
      beat_id_o    = ax_id_i;
      beat_size_o  = ax_size_i;
      beat_last_o  = (ax_len_i == '0);
    end else begin
      beat_valid_o = 1'b1;
      beat_addr_o  = addr_q;
      beat_id_o    = id_q;
      beat_size_o  = size_q;
      beat_last_o  = (cnt_q == len_t'(1));
    end
  end

  assign beat_fire      = beat_valid_o && beat_ready_i;
  assign ax_ready_o     = (state_q == BURST_IDLE) && beat_fire;
  assign burst_active_o = (state_q == BURST_BEATS);

  // INCR step of 2**size bytes.
  assign next_addr = beat_addr_o + (addr_t'(1) << beat_size_o);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= BURST_IDLE;
      cnt_q   <= '0;
    end else if (beat_fire) begin
      if (state_q == BURST_IDLE) begin
        if (ax_len_i != '0) begin
          state_q <= BURST_BEATS;
          cnt_q   <= ax_len_i;
        end
      end else begin
        cnt_q <= cnt_q - len_t'(1);
        if (cnt_q == len_t'(1)) begin
          state_q <= BURST_IDLE;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_fire) begin
      addr_q <= next_addr;
      if (state_q == BURST_IDLE) begin
        id_q   <= ax_id_i;
        size_q <= ax_size_i;
      end
    end
  end

endmodule

// ==== logic/meta_fifo.sv ====
`include "bridge_settings.svh"

module meta_fifo (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             push_i,
  input  bridge_pkg::id_t  push_id_i,
  input  logic             push_write_i,
  input  logic             push_last_i,
  input  logic             pop_i,
  output logic             full_o,
  output logic             empty_o,
  output bridge_pkg::id_t  head_id_o,
  output logic             head_write_o,
  output logic             head_last_o
);
  import bridge_pkg::*;

  localparam int unsigned DEPTH = `BRIDGE_META_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  id_t              id_mem    [DEPTH];
  logic             write_mem [DEPTH];
  logic             last_mem  [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             no_entry;
  logic             store;
  logic             take;

  assign no_entry = (cnt_q == '0);

  // A push popped in the same cycle while empty bypasses the storage.
  assign store = push_i && !(no_entry && pop_i);
  assign take  = pop_i && !no_entry;

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = no_entry && !push_i;

  assign head_id_o    = no_entry ? push_id_i    : id_mem[rd_ptr_q];
  assign head_write_o = no_entry ? push_write_i : write_mem[rd_ptr_q];
  assign head_last_o  = no_entry ? push_last_i  : last_mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (store) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (take) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      cnt_q <= cnt_q + CNT_W'(store) - CNT_W'(take);
    end
  end

  always_ff @(posedge clk_i) begin
    if (store) begin
      id_mem[wr_ptr_q]    <= push_id_i;
      write_mem[wr_ptr_q] <= push_write_i;
      last_mem[wr_ptr_q]  <= push_last_i;
    end
  end

endmodule

// ==== logic/rsp_router.sv ====
module rsp_router (
  input  logic               p_valid_i,
  output logic               p_ready_o,
  input  bridge_pkg::data_t  p_data_i,
  input  logic               p_error_i,
  input  bridge_pkg::id_t    head_id_i,
  input  logic               head_write_i,
  input  logic               head_last_i,
  input  logic               empty_i,
  output logic               pop_o,
  output logic               r_valid_o,
  input  logic               r_ready_i,
  output bridge_pkg::data_t  r_data_o,
  output bridge_pkg::id_t    r_id_o,
  output bridge_pkg::resp_t  r_resp_o,
  output logic               r_last_o,
  output logic               b_valid_o,
  input  logic               b_ready_i,
  output bridge_pkg::id_t    b_id_o,
  output bridge_pkg::resp_t  b_resp_o
);
  import bridge_pkg::*;

  logic  to_r;
  logic  to_b;
  resp_t resp;

  // Reads go to R, last write beats go to B, other write beats are dropped.
  assign to_r = !head_write_i;
  assign to_b = head_write_i && head_last_i;

  assign p_ready_o = !empty_i && (to_r ? r_ready_i : (to_b ? b_ready_i : 1'b1));
  assign pop_o     = p_valid_i && p_ready_o;

  assign resp = p_error_i ? RESP_SLVERR : RESP_OKAY;

  assign r_valid_o = p_valid_i && !empty_i && to_r;
  assign r_data_o  = p_data_i;
  assign r_id_o    = head_id_i;
  assign r_resp_o  = resp;
  assign r_last_o  = head_last_i;

  // B carries the status of the final beat only.
  assign b_valid_o = p_valid_i && !empty_i && to_b;
  assign b_id_o    = head_id_i;
  assign b_resp_o  = resp;

endmodule

// ==== bridge/bridge_ctrl.sv ====
module bridge_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               rd_beat_valid_i,
  output logic               rd_beat_ready_o,
  input  bridge_pkg::addr_t  rd_beat_addr_i,
  input  bridge_pkg::id_t    rd_beat_id_i,
  input  bridge_pkg::size_t  rd_beat_size_i,
  input  logic               rd_beat_last_i,
  input  logic               rd_burst_active_i,
  input  logic               wr_beat_valid_i,
  output logic               wr_beat_ready_o,
  input  bridge_pkg::addr_t  wr_beat_addr_i,
  input  bridge_pkg::id_t    wr_beat_id_i,
  input  bridge_pkg::size_t  wr_beat_size_i,
  input  logic               wr_beat_last_i,
  input  logic               wr_burst_active_i,
  input  logic               w_valid_i,
  output logic               w_ready_o,
  input  bridge_pkg::data_t  w_data_i,
  input  bridge_pkg::strb_t  w_strb_i,
  output logic               q_valid_o,
  input  logic               q_ready_i,
  output bridge_pkg::addr_t  q_addr_o,
  output logic               q_write_o,
  output bridge_pkg::data_t  q_data_o,
  output bridge_pkg::strb_t  q_strb_o,
  output bridge_pkg::size_t  q_size_o,
  input  logic               meta_full_i,
  output logic               meta_push_o,
  output bridge_pkg::id_t    meta_id_o,
  output logic               meta_write_o,
  output logic               meta_last_o
);
  import bridge_pkg::*;

  arb_state_e arb_q;
  logic       sel_q;
  logic       sel_wr;
  logic       rd_elig;
  logic       wr_elig;
  logic       fire;

  // A write beat needs its W data at the same time.
  assign rd_elig = rd_beat_valid_i;
  assign wr_elig = wr_beat_valid_i && w_valid_i;

  always_comb begin
    sel_wr = sel_q;
    if (arb_q == ARB_FREE) begin
      if (wr_elig && !rd_elig) begin
        sel_wr = 1'b1;
      end else if (rd_elig && !wr_elig) begin
        sel_wr = 1'b0;
      end else if (wr_elig && rd_elig) begin
        // Ongoing bursts first, then round robin.
        if (wr_burst_active_i) begin
          sel_wr = 1'b1;
        end else if (rd_burst_active_i) begin
          sel_wr = 1'b0;
        end else begin
          sel_wr = !sel_q;
        end
      end
    end
  end

  assign q_valid_o = (sel_wr ? wr_elig : rd_elig) && !meta_full_i;
  assign fire      = q_valid_o && q_ready_i;

  assign rd_beat_ready_o = fire && !sel_wr;
  assign wr_beat_ready_o = fire && sel_wr;
  assign w_ready_o       = fire && sel_wr;

  assign q_addr_o  = sel_wr ? wr_beat_addr_i : rd_beat_addr_i;
  assign q_write_o = sel_wr;
  assign q_data_o  = sel_wr ? w_data_i : '0;
  assign q_strb_o  = sel_wr ? w_strb_i : '0;
  assign q_size_o  = sel_wr ? wr_beat_size_i : rd_beat_size_i;

  // Routing data is recorded with every accepted request.
  assign meta_push_o  = fire;
  assign meta_id_o    = sel_wr ? wr_beat_id_i : rd_beat_id_i;
  assign meta_write_o = sel_wr;
  assign meta_last_o  = sel_wr ? wr_beat_last_i : rd_beat_last_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      arb_q <= ARB_FREE;
      sel_q <= 1'b0;
    end else if (q_valid_o) begin
      sel_q <= sel_wr;
      arb_q <= fire ? ARB_FREE : ARB_HELD;
    end
  end

endmodule

// ==== bridge/axi_reqrsp_bridge.sv ====
module axi_reqrsp_bridge (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  input  bridge_pkg::addr_t  ar_addr_i,
  input  bridge_pkg::id_t    ar_id_i,
  input  bridge_pkg::len_t   ar_len_i,
  input  bridge_pkg::size_t  ar_size_i,
  input  logic               aw_valid_i,
  output logic               aw_ready_o,
  input  bridge_pkg::addr_t  aw_addr_i,
  input  bridge_pkg::id_t    aw_id_i,
  input  bridge_pkg::len_t   aw_len_i,
  input  bridge_pkg::size_t  aw_size_i,
  input  logic               w_valid_i,
  output logic               w_ready_o,
  input  bridge_pkg::data_t  w_data_i,
  input  bridge_pkg::strb_t  w_strb_i,
  output logic               r_valid_o,
  input  logic               r_ready_i,
  output bridge_pkg::data_t  r_data_o,
  output bridge_pkg::id_t    r_id_o,
  output bridge_pkg::resp_t  r_resp_o,
  output logic               r_last_o,
  output logic               b_valid_o,
  input  logic               b_ready_i,
  output bridge_pkg::id_t    b_id_o,
  output bridge_pkg::resp_t  b_resp_o,
  output logic               q_valid_o,
  input  logic               q_ready_i,
  output bridge_pkg::addr_t  q_addr_o,
  output logic               q_write_o,
  output bridge_pkg::data_t  q_data_o,
  output bridge_pkg::strb_t  q_strb_o,
  output bridge_pkg::size_t  q_size_o,
  input  logic               p_valid_i,
  output logic               p_ready_o,
  input  bridge_pkg::data_t  p_data_i,
  input  logic               p_error_i
);
  import bridge_pkg::*;

  // Read beat stream.
  logic  rd_beat_valid;
  logic  rd_beat_ready;
  addr_t rd_beat_addr;
  id_t   rd_beat_id;
  size_t rd_beat_size;
  logic  rd_beat_last;
  logic  rd_burst_active;

  // Write beat stream.
  logic  wr_beat_valid;
  logic  wr_beat_ready;
  addr_t wr_beat_addr;
  id_t   wr_beat_id;
  size_t wr_beat_size;
  logic  wr_beat_last;
  logic  wr_burst_active;

  // Metadata FIFO.
  logic  meta_push;
  id_t   meta_id;
  logic  meta_write;
  logic  meta_last;
  logic  meta_full;
  logic  meta_empty;
  logic  meta_pop;
  id_t   head_id;
  logic  head_write;
  logic  head_last;

  burst_gen u_rd_gen (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ax_valid_i     (ar_valid_i),
    .ax_ready_o     (ar_ready_o),
    .ax_addr_i      (ar_addr_i),
    .ax_id_i        (ar_id_i),
    .ax_len_i       (ar_len_i),
    .ax_size_i      (ar_size_i),
    .beat_valid_o   (rd_beat_valid),
    .beat_ready_i   (rd_beat_ready),
    .beat_addr_o    (rd_beat_addr),
    .beat_id_o      (rd_beat_id),
    .beat_size_o    (rd_beat_size),
    .beat_last_o    (rd_beat_last),
    .burst_active_o (rd_burst_active)
  );

  burst_gen u_wr_gen (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ax_valid_i     (aw_valid_i),
    .ax_ready_o     (aw_ready_o),
    .ax_addr_i      (aw_addr_i),
    .ax_id_i        (aw_id_i),
    .ax_len_i       (aw_len_i),
    .ax_size_i      (aw_size_i),
    .beat_valid_o   (wr_beat_valid),
    .beat_ready_i   (wr_beat_ready),
    .beat_addr_o    (wr_beat_addr),
    .beat_id_o      (wr_beat_id),
    .beat_size_o    (wr_beat_size),
    .beat_last_o    (wr_beat_last),
    .burst_active_o (wr_burst_active)
  );

  bridge_ctrl u_ctrl (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .rd_beat_valid_i   (rd_beat_valid),
    .rd_beat_ready_o   (rd_beat_ready),
    .rd_beat_addr_i    (rd_beat_addr),
    .rd_beat_id_i      (rd_beat_id),
    .rd_beat_size_i    (rd_beat_size),
    .rd_beat_last_i    (rd_beat_last),
    .rd_burst_active_i (rd_burst_active),
    .wr_beat_valid_i   (wr_beat_valid),
    .wr_beat_ready_o   (wr_beat_ready),
    .wr_beat_addr_i    (wr_beat_addr),
    .wr_beat_id_i      (wr_beat_id),
    .wr_beat_size_i    (wr_beat_size),
    .wr_beat_last_i    (wr_beat_last),
    .wr_burst_active_i (wr_burst_active),
    .w_valid_i         (w_valid_i),
    .w_ready_o         (w_ready_o),
    .w_data_i          (w_data_i),
    .w_strb_i          (w_strb_i),
    .q_valid_o         (q_valid_o),
    .q_ready_i         (q_ready_i),
    .q_addr_o          (q_addr_o),
    .q_write_o         (q_write_o),
    .q_data_o          (q_data_o),
    .q_strb_o          (q_strb_o),
    .q_size_o          (q_size_o),
    .meta_full_i       (meta_full),
    .meta_push_o       (meta_push),
    .meta_id_o         (meta_id),
    .meta_write_o      (meta_write),
    .meta_last_o       (meta_last)
  );

  meta_fifo u_meta (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (meta_push),
    .push_id_i    (meta_id),
    .push_write_i (meta_write),
    .push_last_i  (meta_last),
    .pop_i        (meta_pop),
    .full_o       (meta_full),
    .empty_o      (meta_empty),
    .head_id_o    (head_id),
    .head_write_o (head_write),
    .head_last_o  (head_last)
  );

  rsp_router u_router (
    .p_valid_i    (p_valid_i),
    .p_ready_o    (p_ready_o),
    .p_data_i     (p_data_i),
    .p_error_i    (p_error_i),
    .head_id_i    (head_id),
    .head_write_i (head_write),
    .head_last_i  (head_last),
    .empty_i      (meta_empty),
    .pop_o        (meta_pop),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .r_data_o     (r_data_o),
    .r_id_o       (r_id_o),
    .r_resp_o     (r_resp_o),
    .r_last_o     (r_last_o),
    .b_valid_o    (b_valid_o),
    .b_ready_i    (b_ready_i),
    .b_id_o       (b_id_o),
    .b_resp_o     (b_resp_o)
  );

endmodule

// ==== verif/axi_reqrsp_bridge_props.sv ====
module axi_reqrsp_bridge_props (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               q_valid_o,
  input logic               q_ready_i,
  input bridge_pkg::addr_t  q_addr_o,
  input logic               q_write_o,
  input bridge_pkg::data_t  q_data_o,
  input bridge_pkg::strb_t  q_strb_o,
  input bridge_pkg::size_t  q_size_o,
  input logic               r_valid_o,
  input logic               r_ready_i,
  input bridge_pkg::data_t  r_data_o,
  input logic               b_valid_o,
  input logic               b_ready_i,
  input bridge_pkg::id_t    b_id_o,
  input logic               ar_ready_o,
  input logic               aw_ready_o,
  input logic               w_ready_o,
  input logic               p_ready_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // A stalled request keeps its payload until q_ready.
  q_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    q_valid_o && !q_ready_i |=> q_valid_o && $stable(q_addr_o) && $stable(q_write_o) &&
      $stable(q_data_o) && $stable(q_strb_o) && $stable(q_size_o))
  else begin
    $error("q request changed before it was accepted");
    fail_count++;
  end

  r_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o))
  else begin
    $error("R beat changed before it was accepted");
    fail_count++;
  end

  b_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_id_o))
  else begin
    $error("B response changed before it was accepted");
    fail_count++;
  end

  // Everything is quiet in the first cycle out of reset.
  reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !(q_valid_o || r_valid_o || b_valid_o || ar_ready_o ||
      aw_ready_o || w_ready_o || p_ready_o))
  else begin
    $error("handshake signal high in the first cycle after reset");
    fail_count++;
  end

endmodule

bind axi_reqrsp_bridge axi_reqrsp_bridge_props u_props (.*);

// ==== verif/tb_mem_model.sv ====
`include "bridge_settings.svh"

module tb_mem_model (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               q_valid_i,
  output logic               q_ready_o,
  input  bridge_pkg::addr_t  q_addr_i,
  input  logic               q_write_i,
  input  bridge_pkg::data_t  q_data_i,
  input  bridge_pkg::strb_t  q_strb_i,
  output logic               p_valid_o,
  input  logic               p_ready_i,
  output bridge_pkg::data_t  p_data_o,
  output logic               p_error_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import bridge_pkg::*;

  localparam int MEM_WORDS = 1 << (`BRIDGE_ADDR_W - 2);
  localparam int ERR_BIT   = 15;

  data_t       mem [MEM_WORDS];
  data_t       rsp_data_q [$];
  logic        rsp_err_q [$];
  integer      seed;
  logic [31:0] rnd;
  logic        in_reset;
  logic        q_fire;
  logic        p_fire;
  int          i;

  initial begin
    seed      = 32'h07a69fdc;
    q_ready_o = 1'b0;
    p_valid_o = 1'b0;
    p_data_o  = '0;
    p_error_o = 1'b0;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {16'h5a5a ^ 16'(i), 16'(i)};
    end
    forever begin
      // Handshakes are decided mid-cycle and complete at the next edge.
      @(negedge clk_i);
      in_reset = !rst_n_i;
      q_fire   = !in_reset && q_valid_i && q_ready_o;
      p_fire   = !in_reset && p_valid_o && p_ready_i;
      if (q_fire) begin
        if (q_write_i && !q_addr_i[ERR_BIT]) begin
          for (i = 0; i < `BRIDGE_DATA_W / 8; i++) begin
            if (q_strb_i[i]) begin
              mem[q_addr_i[`BRIDGE_ADDR_W-1:2]][8*i +: 8] = q_data_i[8*i +: 8];
            end
          end
        end
        rsp_data_q.push_back((q_write_i || q_addr_i[ERR_BIT]) ? '0 :
                             mem[q_addr_i[`BRIDGE_ADDR_W-1:2]]);
        rsp_err_q.push_back(q_addr_i[ERR_BIT]);
      end
      @(posedge clk_i);
      #1;
      rnd = $random(seed);
      if (p_fire) begin
        p_valid_o = 1'b0;
        void'(rsp_data_q.pop_front());
        void'(rsp_err_q.pop_front());
      end
      // Stall one request in four.
      q_ready_o = !in_reset && (rnd[1:0] != 2'b00);
      if (!p_valid_o && rsp_data_q.size() != 0 && rnd[2]) begin
        p_valid_o = 1'b1;
        p_data_o  = rsp_data_q[0];
        p_error_o = rsp_err_q[0];
      end
    end
  end

endmodule

// ==== verif/tb_axi_reqrsp_bridge.sv ====
`include "bridge_settings.svh"

module tb_axi_reqrsp_bridge;
  timeunit 1ns;
  timeprecision 1ps;
  import bridge_pkg::*;

  localparam int MEM_WORDS    = 1 << (`BRIDGE_ADDR_W - 2);
  localparam int ERR_BIT      = 15;
  localparam int HS_TIMEOUT   = 500;
  localparam int DONE_TIMEOUT = 5000;

  logic  clk;
  logic  rst_n;
  logic  ar_valid;
  logic  ar_ready;
  addr_t ar_addr;
  id_t   ar_id;
  len_t  ar_len;
  size_t ar_size;
  logic  aw_valid;
  logic  aw_ready;
  addr_t aw_addr;
  id_t   aw_id;
  len_t  aw_len;
  size_t aw_size;
  logic  w_valid;
  logic  w_ready;
  data_t w_data;
  strb_t w_strb;
  logic  r_valid;
  logic  r_ready;
  data_t r_data;
  id_t   r_id;
  resp_t r_resp;
  logic  r_last;
  logic  b_valid;
  logic  b_ready;
  id_t   b_id;
  resp_t b_resp;
  logic  q_valid;
  logic  q_ready;
  addr_t q_addr;
  logic  q_write;
  data_t q_data;
  strb_t q_strb;
  size_t q_size;
  logic  p_valid;
  logic  p_ready;
  data_t p_data;
  logic  p_error;

  integer seed;
  logic   random_ready;
  data_t  shadow [MEM_WORDS];
  data_t  wr_data [16];
  strb_t  wr_strb [16];

  // Expected R beats and B responses, in AXI order per channel.
  data_t exp_r_data [$];
  id_t   exp_r_id [$];
  resp_t exp_r_resp [$];
  logic  exp_r_last [$];
  string exp_r_name [$];
  id_t   exp_b_id [$];
  resp_t exp_b_resp [$];
  string exp_b_name [$];

  axi_reqrsp_bridge dut_i (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .ar_valid_i (ar_valid),
    .ar_ready_o (ar_ready),
    .ar_addr_i  (ar_addr),
    .ar_id_i    (ar_id),
    .ar_len_i   (ar_len),
    .ar_size_i  (ar_size),
    .aw_valid_i (aw_valid),
    .aw_ready_o (aw_ready),
    .aw_addr_i  (aw_addr),
    .aw_id_i    (aw_id),
    .aw_len_i   (aw_len),
    .aw_size_i  (aw_size),
    .w_valid_i  (w_valid),
    .w_ready_o  (w_ready),
    .w_data_i   (w_data),
    .w_strb_i   (w_strb),
    .r_valid_o  (r_valid),
    .r_ready_i  (r_ready),
    .r_data_o   (r_data),
    .r_id_o     (r_id),
    .r_resp_o   (r_resp),
    .r_last_o   (r_last),
    .b_valid_o  (b_valid),
    .b_ready_i  (b_ready),
    .b_id_o     (b_id),
    .b_resp_o   (b_resp),
    .q_valid_o  (q_valid),
    .q_ready_i  (q_ready),
    .q_addr_o   (q_addr),
    .q_write_o  (q_write),
    .q_data_o   (q_data),
    .q_strb_o   (q_strb),
    .q_size_o   (q_size),
    .p_valid_i  (p_valid),
    .p_ready_o  (p_ready),
    .p_data_i   (p_data),
    .p_error_i  (p_error)
  );

  tb_mem_model u_mem (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .q_valid_i (q_valid),
    .q_ready_o (q_ready),
    .q_addr_i  (q_addr),
    .q_write_i (q_write),
    .q_data_i  (q_data),
    .q_strb_i  (q_strb),
    .p_valid_o (p_valid),
    .p_ready_i (p_ready),
    .p_data_o  (p_data),
    .p_error_o (p_error)
  );

  always #4 clk = ~clk;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Run stopped on first error.");
  endtask

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("[FAIL] %s %s expected %h actual %h", name, what, exp, act);
    $display("Verification failed");
    $fatal(1, "Run stopped on first mismatch.");
  endtask

  // A failed bound property ends the run at once.
  always @(dut_i.u_props.fail_count) begin
    if (dut_i.u_props.fail_count != 0) begin
      stop_run("A bound handshake property failed");
    end
  end

  // Data, response and last flag of one beat, from the shadow memory.
  function automatic logic [`BRIDGE_DATA_W+2:0] expected_word(input addr_t addr, input int beat,
                                                              input int last_beat);
    data_t d;
    resp_t resp;
    if (addr[ERR_BIT]) begin
      d    = '0;
      resp = RESP_SLVERR;
    end else begin
      d    = shadow[addr[`BRIDGE_ADDR_W-1:2]];
      resp = RESP_OKAY;
    end
    return {d, resp, beat == last_beat};
  endfunction

  task automatic shadow_write(input addr_t addr, input data_t data, input strb_t strb);
    int b;
    if (!addr[ERR_BIT]) begin
      for (b = 0; b < `BRIDGE_DATA_W / 8; b++) begin
        if (strb[b]) begin
          shadow[addr[`BRIDGE_ADDR_W-1:2]][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic issue_read(input string name, input id_t id, input addr_t addr,
                            input len_t len, input size_t size);
    logic [`BRIDGE_DATA_W+2:0] exp;
    int beat;
    int wait_cnt;
    for (beat = 0; beat <= int'(len); beat++) begin
      exp = expected_word(addr + (addr_t'(beat) << size), beat, int'(len));
      exp_r_data.push_back(exp[`BRIDGE_DATA_W+2:3]);
      exp_r_resp.push_back(exp[2:1]);
      exp_r_last.push_back(exp[0]);
      exp_r_id.push_back(id);
      exp_r_name.push_back(name);
    end
    ar_valid = 1'b1;
    ar_addr  = addr;
    ar_id    = id;
    ar_len   = len;
    ar_size  = size;
    wait_cnt = 0;
    @(negedge clk);
    while (!ar_ready) begin
      wait_cnt++;
      if (wait_cnt > HS_TIMEOUT) begin
        stop_run({"AR handshake never came in ", name});
      end
      @(negedge clk);
    end
    // The first beat goes downstream in the same cycle.
    assert (q_size == size) else report_mismatch(name, "q_size", size, q_size);
    @(posedge clk);
    #1;
    ar_valid = 1'b0;
  endtask

  // Beats come from wr_data and wr_strb.
  task automatic issue_write(input string name, input id_t id, input addr_t addr,
                             input len_t len, input size_t size);
    addr_t last_addr;
    int    beat;
    int    wait_cnt;
    for (beat = 0; beat <= int'(len); beat++) begin
      shadow_write(addr + (addr_t'(beat) << size), wr_data[beat], wr_strb[beat]);
    end
    last_addr = addr + (addr_t'(len) << size);
    exp_b_id.push_back(id);
    exp_b_resp.push_back(last_addr[ERR_BIT] ? RESP_SLVERR : RESP_OKAY);
    exp_b_name.push_back(name);
    aw_valid = 1'b1;
    aw_addr  = addr;
    aw_id    = id;
    aw_len   = len;
    aw_size  = size;
    w_valid  = 1'b1;
    for (beat = 0; beat <= int'(len); beat++) begin
      w_data   = wr_data[beat];
      w_strb   = wr_strb[beat];
      wait_cnt = 0;
      @(negedge clk);
      while (!w_ready) begin
        wait_cnt++;
        if (wait_cnt > HS_TIMEOUT) begin
          stop_run({"W handshake never came in ", name});
        end
        @(negedge clk);
      end
      // AW is taken together with the first W beat only.
      assert (aw_ready == (beat == 0))
        else report_mismatch(name, "aw_ready", beat == 0, aw_ready);
      assert (q_size == size) else report_mismatch(name, "q_size", size, q_size);
      @(posedge clk);
      #1;
      aw_valid = 1'b0;
    end
    w_valid = 1'b0;
  endtask

  task automatic wait_responses(input string name);
    int wait_cnt;
    wait_cnt = 0;
    while (exp_r_data.size() != 0 || exp_b_id.size() != 0) begin
      @(posedge clk);
      wait_cnt++;
      if (wait_cnt > DONE_TIMEOUT) begin
        stop_run({"R or B handshake never came in ", name});
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_r_beat();
    string name;
    assert (exp_r_data.size() != 0) else stop_run("R beat arrived with no read outstanding");
    name = exp_r_name.pop_front();
    assert (r_data == exp_r_data[0]) else report_mismatch(name, "r_data", exp_r_data[0], r_data);
    assert (r_id == exp_r_id[0]) else report_mismatch(name, "r_id", exp_r_id[0], r_id);
    assert (r_resp == exp_r_resp[0]) else report_mismatch(name, "r_resp", exp_r_resp[0], r_resp);
    assert (r_last == exp_r_last[0]) else report_mismatch(name, "r_last", exp_r_last[0], r_last);
    void'(exp_r_data.pop_front());
    void'(exp_r_id.pop_front());
    void'(exp_r_resp.pop_front());
    void'(exp_r_last.pop_front());
  endtask

  task automatic check_b_resp();
    string name;
    assert (exp_b_id.size() != 0) else stop_run("B response arrived with no write outstanding");
    name = exp_b_name.pop_front();
    assert (b_id == exp_b_id[0]) else report_mismatch(name, "b_id", exp_b_id[0], b_id);
    assert (b_resp == exp_b_resp[0]) else report_mismatch(name, "b_resp", exp_b_resp[0], b_resp);
    void'(exp_b_id.pop_front());
    void'(exp_b_resp.pop_front());
  endtask

  // Handshakes are checked mid-cycle, where all inputs have settled.
  always @(negedge clk) begin
    if (rst_n) begin
      if (r_valid && r_ready) begin
        check_r_beat();
      end
      if (b_valid && b_ready) begin
        check_b_resp();
      end
    end
  end

  always @(posedge clk) begin
    #1;
    if (random_ready) begin
      r_ready = ($random(seed) & 3) != 0;
      b_ready = ($random(seed) & 1) != 0;
    end else begin
      r_ready = 1'b1;
      b_ready = 1'b1;
    end
  end

  initial begin
    int i;
    int iter;
    clk          = 1'b0;
    rst_n        = 1'b0;
    seed         = 32'h07a69fdc;
    random_ready = 1'b0;
    ar_valid     = 1'b0;
    ar_addr      = '0;
    ar_id        = '0;
    ar_len       = '0;
    ar_size      = '0;
    aw_valid     = 1'b0;
    aw_addr      = '0;
    aw_id        = '0;
    aw_len       = '0;
    aw_size      = '0;
    w_valid      = 1'b0;
    w_data       = '0;
    w_strb       = '0;
    r_ready      = 1'b0;
    b_ready      = 1'b0;
    for (i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = {16'h5a5a ^ 16'(i), 16'(i)};
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    wr_data[0] = 32'hdeadbeef;
    wr_strb[0] = 4'hf;
    issue_write("single_write", 4'h1, 16'h0100, 8'd0, 3'd2);
    wait_responses("single_write");
    issue_read("single_read", 4'h2, 16'h0100, 8'd0, 3'd2);
    wait_responses("single_read");

    // Mixed strobes merge with the previous contents.
    for (i = 0; i < 4; i++) begin
      wr_data[i] = 32'h01234567 ^ (32'h11111111 * (i + 1));
    end
    wr_strb[0] = 4'hf;
    wr_strb[1] = 4'h5;
    wr_strb[2] = 4'ha;
    wr_strb[3] = 4'h3;
    issue_write("burst_write", 4'h3, 16'h0200, 8'd3, 3'd2);
    wait_responses("burst_write");
    issue_read("burst_read", 4'h4, 16'h0200, 8'd3, 3'd2);
    wait_responses("burst_read");

    // Halfword beats land in alternating lanes.
    for (i = 0; i < 4; i++) begin
      wr_data[i] = i[0] ? {16'hc100 + 16'(i), 16'hdead} : {16'hbeef, 16'hc100 + 16'(i)};
      wr_strb[i] = i[0] ? 4'b1100 : 4'b0011;
    end
    issue_write("narrow_write", 4'h5, 16'h0300, 8'd3, 3'd1);
    wait_responses("narrow_write");
    issue_read("narrow_read", 4'h6, 16'h0300, 8'd1, 3'd2);
    wait_responses("narrow_read");

    for (i = 0; i < 3; i++) begin
      wr_data[i] = 32'hbad00000 + i;
      wr_strb[i] = 4'hf;
    end
    issue_write("error_write", 4'h7, 16'h8040, 8'd2, 3'd2);
    wait_responses("error_write");
    issue_read("error_read", 4'h8, 16'h8040, 8'd2, 3'd2);
    wait_responses("error_read");

    @(negedge clk);
    random_ready = 1'b1;
    @(posedge clk);
    #1;
    for (iter = 0; iter < 6; iter++) begin
      for (i = 0; i < 8; i++) begin
        wr_data[i] = data_t'(32'h9e3779b9 * (iter * 8 + i + 1));
        wr_strb[i] = strb_t'(iter * 3 + i * 5 + 1);
      end
      fork
        issue_write("concurrent_write", id_t'(iter), 16'h1000 + addr_t'(iter * 32), 8'd7, 3'd2);
        issue_read("concurrent_read", id_t'(iter + 8), 16'h2000 + addr_t'(iter * 32), 8'd7, 3'd2);
      join
    end
    wait_responses("concurrent");

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== axi_reqrsp_bridge.f ====
+incdir+common
common/bridge_pkg.sv
logic/burst_gen.sv
logic/meta_fifo.sv
logic/rsp_router.sv
bridge/bridge_ctrl.sv
bridge/axi_reqrsp_bridge.sv
verif/axi_reqrsp_bridge_props.sv
verif/tb_mem_model.sv
verif/tb_axi_reqrsp_bridge.sv
